/* hw/brisc_pkg.sv */
package brisc_pkg;

  // Pipeline widths
  parameter int XLEN = 32;
  parameter int REG_BITS = 5;
  parameter int ADDRESS_WIDTH = 32;

  // Four words per line
  parameter int CACHE_LINE_WIDTH = 128;

  // Writeback result source
  typedef enum logic [1:0] {
    FROM_ALU   = 2'd0,
    FROM_C     = 2'd1,
    FROM_PC4   = 2'd2,
    FROM_DELTA = 2'd3
  } result_src_e;

  // Memory access size
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } data_size_e;

  // Stage contents as seen by the store buffer
  typedef enum logic [1:0] {
    IS_LOAD  = 2'd0,
    IS_STORE = 2'd1,
    OTHER    = 2'd2
  } stb_ctrl_e;

endpackage

/* hw/store_buffer.sv */
module store_buffer #(
  parameter int STB_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic wait_mem,
  input  brisc_pkg::stb_ctrl_e stb_ctrl,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] addr,
  input  brisc_pkg::data_size_e data_size,
  input  logic [brisc_pkg::XLEN-1:0] write_data,
  input  logic cache_accept,
  output logic cache_write,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] cache_write_addr,
  output logic [brisc_pkg::XLEN-1:0] cache_write_data,
  output brisc_pkg::data_size_e cache_write_size,
  output logic read_valid,
  output logic [brisc_pkg::XLEN-1:0] read_data,
  output logic drain_stall
);
  localparam int PTR_BITS = (STB_DEPTH > 1) ? $clog2(STB_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(STB_DEPTH + 1);
  localparam int AW = brisc_pkg::ADDRESS_WIDTH;

  logic [AW-1:0] ent_addr [STB_DEPTH];
  logic [brisc_pkg::XLEN-1:0] ent_data [STB_DEPTH];
  brisc_pkg::data_size_e ent_size [STB_DEPTH];

  logic [PTR_BITS-1:0] head;
  logic [PTR_BITS-1:0] tail;
  logic [CNT_BITS-1:0] count;
  logic full;
  logic push;
  logic pop;

  logic [3:0] load_mask;
  logic overlap_any;
  logic exact;
  logic force_drain;
  logic [PTR_BITS-1:0] young_slot;

  // Bytes touched within the word
  function automatic logic [3:0] size_mask(input brisc_pkg::data_size_e size,
                                           input logic [1:0] offset);
    logic [3:0] base;
    case (size)
      brisc_pkg::SIZE_B: base = 4'b0001;
      brisc_pkg::SIZE_H: base = 4'b0011;
      default:           base = 4'b1111;
    endcase
    return base << offset;
  endfunction

  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(STB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign load_mask = size_mask(data_size, addr[1:0]);

  // Walk oldest to youngest so the last overlap found is the youngest
  always_comb begin
    logic [PTR_BITS-1:0] slot;
    overlap_any = 1'b0;
    young_slot = head;
    for (int i = 0; i < STB_DEPTH; i++) begin
      slot = PTR_BITS'((int'(head) + i) % STB_DEPTH);
      if (i < int'(count) && ent_addr[slot][AW-1:2] == addr[AW-1:2] &&
          |(size_mask(ent_size[slot], ent_addr[slot][1:0]) & load_mask)) begin
        overlap_any = 1'b1;
        young_slot = slot;
      end
    end
  end

  assign exact = (ent_addr[young_slot] == addr) && (ent_size[young_slot] == data_size);
  assign read_valid = (stb_ctrl == brisc_pkg::IS_LOAD) && overlap_any && exact;
  assign force_drain = (stb_ctrl == brisc_pkg::IS_LOAD) && overlap_any && !exact;

  always_comb begin
    case (ent_size[young_slot])
      brisc_pkg::SIZE_B: read_data = brisc_pkg::XLEN'(ent_data[young_slot][7:0]);
      brisc_pkg::SIZE_H: read_data = brisc_pkg::XLEN'(ent_data[young_slot][15:0]);
      default:           read_data = ent_data[young_slot];
    endcase
  end

  assign full = (count == CNT_BITS'(STB_DEPTH));
  assign drain_stall = full || force_drain;
  assign push = (stb_ctrl == brisc_pkg::IS_STORE) && !full;

  // Drain in idle slots, when full, or to clear a partial overlap
  assign cache_write = (count != '0) && !wait_mem &&
                       ((stb_ctrl == brisc_pkg::OTHER) || full || force_drain);
  assign pop = cache_write && cache_accept;

  assign cache_write_addr = ent_addr[head];
  assign cache_write_data = ent_data[head];
  assign cache_write_size = ent_size[head];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= ptr_inc(tail);
      end
      if (pop) begin
        head <= ptr_inc(head);
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ent_addr[tail] <= addr;
      ent_data[tail] <= write_data;
      ent_size[tail] <= data_size;
    end
  end

endmodule

/* hw/dcache.sv */
module dcache #(
  parameter int CACHE_SETS = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic is_load,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] addr,
  input  brisc_pkg::data_size_e data_size,
  output logic [brisc_pkg::XLEN-1:0] read_data,
  output logic miss,
  input  logic write_en,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] write_addr,
  input  logic [brisc_pkg::XLEN-1:0] write_data,
  input  brisc_pkg::data_size_e write_size,
  output logic mem_req,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] mem_req_addr,
  output logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_req_data,
  output logic mem_req_write,
  input  logic fill,
  input  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] fill_data,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] fill_addr
);
  localparam int AW = brisc_pkg::ADDRESS_WIDTH;
  localparam int LW = brisc_pkg::CACHE_LINE_WIDTH;
  localparam int LINE_BYTES = LW / 8;
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int INDEX_BITS = $clog2(CACHE_SETS);
  localparam int TAG_BITS = AW - INDEX_BITS - OFFSET_BITS;

  typedef enum logic [1:0] {
    IDLE,
    EVICT,
    REFILL
  } state_e;

  state_e state;

  logic [LW-1:0] lines [CACHE_SETS];
  logic [TAG_BITS-1:0] tags [CACHE_SETS];
  logic [CACHE_SETS-1:0] valid;
  logic [CACHE_SETS-1:0] dirty;

  logic look_en;
  logic [AW-1:0] look_addr;
  logic [INDEX_BITS-1:0] look_idx;
  logic [TAG_BITS-1:0] look_tag;
  logic hit;

  logic [INDEX_BITS-1:0] miss_idx;
  logic [AW-1:0] evict_addr;
  logic [AW-1:0] refill_addr;
  logic [INDEX_BITS-1:0] fill_idx;

  logic [3:0] word_mask;
  logic [LINE_BYTES-1:0] wr_be;
  logic [LW-1:0] wr_line;
  logic [LW-1:0] rd_bytes;

  // Pending store has priority over the load port
  assign look_en = write_en || is_load;
  assign look_addr = write_en ? write_addr : addr;
  assign look_idx = look_addr[OFFSET_BITS +: INDEX_BITS];
  assign look_tag = look_addr[AW-1 -: TAG_BITS];
  assign hit = valid[look_idx] && (tags[look_idx] == look_tag);
  assign fill_idx = fill_addr[OFFSET_BITS +: INDEX_BITS];

  assign miss = (state != IDLE) || (look_en && !hit);

  assign mem_req = (state != IDLE);
  assign mem_req_write = (state == EVICT);
  assign mem_req_addr = (state == EVICT) ? evict_addr : refill_addr;
  assign mem_req_data = lines[miss_idx];

  // Zero-extended load data
  assign rd_bytes = lines[look_idx] >> {look_addr[OFFSET_BITS-1:0], 3'b000};

  always_comb begin
    case (data_size)
      brisc_pkg::SIZE_B: read_data = brisc_pkg::XLEN'(rd_bytes[7:0]);
      brisc_pkg::SIZE_H: read_data = brisc_pkg::XLEN'(rd_bytes[15:0]);
      default:           read_data = rd_bytes[brisc_pkg::XLEN-1:0];
    endcase
  end

  // Byte enables for a store into the line
  always_comb begin
    case (write_size)
      brisc_pkg::SIZE_B: word_mask = 4'b0001;
      brisc_pkg::SIZE_H: word_mask = 4'b0011;
      default:           word_mask = 4'b1111;
    endcase
  end

  assign wr_be = LINE_BYTES'(word_mask) << write_addr[OFFSET_BITS-1:0];
  assign wr_line = LW'(write_data) << {write_addr[OFFSET_BITS-1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      valid <= '0;
      dirty <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (look_en && !hit) begin
            state <= (valid[look_idx] && dirty[look_idx]) ? EVICT : REFILL;
          end else if (write_en) begin
            dirty[look_idx] <= 1'b1;
          end
        end
        EVICT: begin
          if (fill) begin
            state <= REFILL;
          end
        end
        REFILL: begin
          if (fill) begin
            valid[fill_idx] <= 1'b1;
            dirty[fill_idx] <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Victim and refill addresses, captured when the miss is seen
  always_ff @(posedge clk) begin
    if (state == IDLE && look_en && !hit) begin
      miss_idx <= look_idx;
      evict_addr <= {tags[look_idx], look_idx, {OFFSET_BITS{1'b0}}};
      refill_addr <= {look_addr[AW-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (state == REFILL && fill) begin
      lines[fill_idx] <= fill_data;
      tags[fill_idx] <= fill_addr[AW-1 -: TAG_BITS];
    end else if (state == IDLE && write_en && hit) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_be[b]) begin
          lines[look_idx][8*b +: 8] <= wr_line[8*b +: 8];
        end
      end
    end
  end

endmodule

/* hw/line_memory.sv */
module line_memory #(
  parameter int MEM_WORDS = 64,
  parameter int MEM_LATENCY = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic mem_req,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] mem_req_addr,
  input  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_req_data,
  input  logic mem_req_write,
  output logic fill,
  output logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] fill_data,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] fill_addr
);
  localparam int OFFSET_BITS = $clog2(brisc_pkg::CACHE_LINE_WIDTH / 8);
  localparam int INDEX_BITS = $clog2(MEM_WORDS);
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] storage [MEM_WORDS];

  logic busy;
  logic accept;
  logic done;
  logic [CNT_BITS-1:0] cnt;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] req_addr;
  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] req_data;
  logic req_write;
  logic [INDEX_BITS-1:0] req_idx;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      storage[i] = '0;
    end
  end

  // Requester still holds mem_req during the fill cycle
  assign accept = !busy && mem_req && !fill;
  assign done = busy && (cnt == CNT_BITS'(MEM_LATENCY - 1));
  assign req_idx = req_addr[OFFSET_BITS +: INDEX_BITS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt <= '0;
      fill <= 1'b0;
    end else begin
      fill <= done;
      if (accept) begin
        busy <= 1'b1;
        cnt <= '0;
      end else if (done) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr <= mem_req_addr;
      req_data <= mem_req_data;
      req_write <= mem_req_write;
    end
    if (done) begin
      fill_addr <= req_addr;
      if (req_write) begin
        storage[req_idx] <= req_data;
        fill_data <= '0;
      end else begin
        fill_data <= storage[req_idx];
      end
    end
  end

endmodule

/* hw/cache_stage.sv */
module cache_stage #(
  parameter int CACHE_SETS = 8,
  parameter int STB_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic stall_in,
  input  logic flush_in,

  input  logic [brisc_pkg::XLEN-1:0] alu_res_in,
  input  logic [brisc_pkg::XLEN-1:0] write_data_in,
  input  logic [brisc_pkg::XLEN-1:0] pc_plus4_in,
  input  logic [brisc_pkg::XLEN-1:0] pc_delta_in,
  input  logic [brisc_pkg::REG_BITS-1:0] rd_in,
  input  logic reg_write_in,
  input  brisc_pkg::result_src_e result_src_in,
  input  logic mem_write_in,
  input  brisc_pkg::data_size_e data_size_in,

  output logic [brisc_pkg::XLEN-1:0] alu_res_out,
  output logic [brisc_pkg::XLEN-1:0] read_data_out,
  output logic [brisc_pkg::XLEN-1:0] pc_plus4_out,
  output logic [brisc_pkg::XLEN-1:0] pc_delta_out,
  output logic [brisc_pkg::REG_BITS-1:0] rd_out,
  output logic reg_write_out,
  output brisc_pkg::result_src_e result_src_out,
  output logic stall_out,

  input  logic fill,
  input  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] fill_data,
  input  logic [brisc_pkg::ADDRESS_WIDTH-1:0] fill_addr,

  output logic mem_req,
  output logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_req_data,
  output logic [brisc_pkg::ADDRESS_WIDTH-1:0] mem_req_addr,
  output logic mem_req_write
);
  logic [brisc_pkg::XLEN-1:0] write_data_q;
  logic mem_write_q;
  brisc_pkg::data_size_e data_size_q;

  logic is_load;
  logic cache_load;
  brisc_pkg::stb_ctrl_e stb_ctrl;

  logic [brisc_pkg::XLEN-1:0] cache_read_data;
  logic cache_miss;
  logic cache_write;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] cache_write_addr;
  logic [brisc_pkg::XLEN-1:0] cache_write_data;
  brisc_pkg::data_size_e cache_write_size;

  logic stb_read_valid;
  logic [brisc_pkg::XLEN-1:0] stb_read_data;
  logic drain_stall;

  // Execute to memory stage register
  always_ff @(posedge clk) begin
    if (!rst_n || flush_in) begin
      alu_res_out <= '0;
      write_data_q <= '0;
      pc_plus4_out <= '0;
      pc_delta_out <= '0;
      rd_out <= '0;
      reg_write_out <= 1'b0;
      result_src_out <= brisc_pkg::FROM_ALU;
      mem_write_q <= 1'b0;
      data_size_q <= brisc_pkg::SIZE_B;
    end else if (!stall_in) begin
      alu_res_out <= alu_res_in;
      write_data_q <= write_data_in;
      pc_plus4_out <= pc_plus4_in;
      pc_delta_out <= pc_delta_in;
      rd_out <= rd_in;
      reg_write_out <= reg_write_in;
      result_src_out <= result_src_in;
      mem_write_q <= mem_write_in;
      data_size_q <= data_size_in;
    end
  end

  assign is_load = (result_src_out == brisc_pkg::FROM_C);

  // A store counts only on the cycle it leaves the stage
  always_comb begin
    if (is_load) begin
      stb_ctrl = brisc_pkg::IS_LOAD;
    end else if (mem_write_q && !stall_in && !flush_in) begin
      stb_ctrl = brisc_pkg::IS_STORE;
    end else begin
      stb_ctrl = brisc_pkg::OTHER;
    end
  end

  // Cache lookup only when the buffer can neither forward nor is draining
  assign cache_load = is_load && !stb_read_valid && !drain_stall;

  assign read_data_out = stb_read_valid ? stb_read_data : cache_read_data;
  assign stall_out = cache_miss || mem_req || drain_stall;

  dcache #(
    .CACHE_SETS(CACHE_SETS)
  ) dcache_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .is_load      (cache_load),
    .addr         (alu_res_out),
    .data_size    (data_size_q),
    .read_data    (cache_read_data),
    .miss         (cache_miss),
    .write_en     (cache_write),
    .write_addr   (cache_write_addr),
    .write_data   (cache_write_data),
    .write_size   (cache_write_size),
    .mem_req      (mem_req),
    .mem_req_addr (mem_req_addr),
    .mem_req_data (mem_req_data),
    .mem_req_write(mem_req_write),
    .fill         (fill),
    .fill_data    (fill_data),
    .fill_addr    (fill_addr)
  );

  store_buffer #(
    .STB_DEPTH(STB_DEPTH)
  ) store_buffer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wait_mem        (mem_req),
    .stb_ctrl        (stb_ctrl),
    .addr            (alu_res_out),
    .data_size       (data_size_q),
    .write_data      (write_data_q),
    .cache_accept    (!cache_miss),
    .cache_write     (cache_write),
    .cache_write_addr(cache_write_addr),
    .cache_write_data(cache_write_data),
    .cache_write_size(cache_write_size),
    .read_valid      (stb_read_valid),
    .read_data       (stb_read_data),
    .drain_stall     (drain_stall)
  );

endmodule

/* hw/mem_stage_top.sv */
module mem_stage_top #(
  parameter int CACHE_SETS = 8,
  parameter int STB_DEPTH = 4,
  parameter int MEM_WORDS = 64,
  parameter int MEM_LATENCY = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic stall_in,
  input  logic flush_in,

  input  logic [brisc_pkg::XLEN-1:0] alu_res_in,
  input  logic [brisc_pkg::XLEN-1:0] write_data_in,
  input  logic [brisc_pkg::XLEN-1:0] pc_plus4_in,
  input  logic [brisc_pkg::XLEN-1:0] pc_delta_in,
  input  logic [brisc_pkg::REG_BITS-1:0] rd_in,
  input  logic reg_write_in,
  input  brisc_pkg::result_src_e result_src_in,
  input  logic mem_write_in,
  input  brisc_pkg::data_size_e data_size_in,

  output logic [brisc_pkg::XLEN-1:0] alu_res_out,
  output logic [brisc_pkg::XLEN-1:0] read_data_out,
  output logic [brisc_pkg::XLEN-1:0] pc_plus4_out,
  output logic [brisc_pkg::XLEN-1:0] pc_delta_out,
  output logic [brisc_pkg::REG_BITS-1:0] rd_out,
  output logic reg_write_out,
  output brisc_pkg::result_src_e result_src_out,
  output logic stall_out
);
  // Line request and fill between cache and memory
  logic mem_req;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] mem_req_addr;
  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] mem_req_data;
  logic mem_req_write;
  logic fill;
  logic [brisc_pkg::CACHE_LINE_WIDTH-1:0] fill_data;
  logic [brisc_pkg::ADDRESS_WIDTH-1:0] fill_addr;

  cache_stage #(
    .CACHE_SETS(CACHE_SETS),
    .STB_DEPTH (STB_DEPTH)
  ) cache_stage_i (.*);

  line_memory #(
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) line_memory_i (.*);

endmodule

/* sim/tb_mem_stage.sv */
module tb_mem_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int XLEN = brisc_pkg::XLEN;
  localparam int REG_BITS = brisc_pkg::REG_BITS;
  localparam int CACHE_SETS = 8;
  localparam int STB_DEPTH = 4;
  localparam int MEM_WORDS = 64;
  localparam int MEM_LATENCY = 4;
  localparam int MEM_BYTES = MEM_WORDS * 16;
  localparam int TEST_LINES = 4 * CACHE_SETS;
  localparam int RANDOM_COUNT = 3000;
  localparam int WAIT_LIMIT = 200;

  typedef struct {
    logic [XLEN-1:0] alu;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] pc4;
    logic [XLEN-1:0] delta;
    logic [REG_BITS-1:0] rd;
    logic rw;
    brisc_pkg::result_src_e src;
    logic mw;
    brisc_pkg::data_size_e size;
  } instr_t;

  logic clk;
  logic rst_n;
  logic stall_in;
  logic flush_in;
  logic [XLEN-1:0] alu_res_in;
  logic [XLEN-1:0] write_data_in;
  logic [XLEN-1:0] pc_plus4_in;
  logic [XLEN-1:0] pc_delta_in;
  logic [REG_BITS-1:0] rd_in;
  logic reg_write_in;
  brisc_pkg::result_src_e result_src_in;
  logic mem_write_in;
  brisc_pkg::data_size_e data_size_in;
  logic [XLEN-1:0] alu_res_out;
  logic [XLEN-1:0] read_data_out;
  logic [XLEN-1:0] pc_plus4_out;
  logic [XLEN-1:0] pc_delta_out;
  logic [REG_BITS-1:0] rd_out;
  logic reg_write_out;
  brisc_pkg::result_src_e result_src_out;
  logic stall_out;

  // Reference model state
  logic [7:0] ref_mem [MEM_BYTES];
  instr_t stage;
  instr_t pending;
  logic pending_valid;
  instr_t drv_instr;
  logic drv_stall;
  logic drv_flush;
  logic random_stalls;

  mem_stage_top #(
    .CACHE_SETS (CACHE_SETS),
    .STB_DEPTH  (STB_DEPTH),
    .MEM_WORDS  (MEM_WORDS),
    .MEM_LATENCY(MEM_LATENCY)
  ) mem_stage_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_BITS-1:0] exp,
                           input logic [REG_BITS-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_src(input string name, input brisc_pkg::result_src_e exp,
                           input brisc_pkg::result_src_e act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s expected %s actual %s", name, exp.name(),
                              act.name()));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic int size_bytes(input brisc_pkg::data_size_e size);
    case (size)
      brisc_pkg::SIZE_B: return 1;
      brisc_pkg::SIZE_H: return 2;
      default:           return 4;
    endcase
  endfunction

  function automatic instr_t bubble();
    instr_t ins;
    ins.alu = '0;
    ins.wdata = '0;
    ins.pc4 = '0;
    ins.delta = '0;
    ins.rd = '0;
    ins.rw = 1'b0;
    ins.src = brisc_pkg::FROM_ALU;
    ins.mw = 1'b0;
    ins.size = brisc_pkg::SIZE_B;
    return ins;
  endfunction

  function automatic instr_t random_instr();
    instr_t ins;
    int unsigned kind;
    logic [XLEN-1:0] addr;
    ins = bubble();
    kind = $urandom % 8;
    case ($urandom % 3)
      0:       ins.size = brisc_pkg::SIZE_B;
      1:       ins.size = brisc_pkg::SIZE_H;
      default: ins.size = brisc_pkg::SIZE_W;
    endcase
    addr = XLEN'(($urandom % TEST_LINES) * 16 + ($urandom % 16));
    if (ins.size == brisc_pkg::SIZE_H) begin
      addr[0] = 1'b0;
    end else if (ins.size == brisc_pkg::SIZE_W) begin
      addr[1:0] = 2'b00;
    end
    ins.wdata = $urandom;
    ins.pc4 = $urandom;
    ins.delta = $urandom;
    ins.rd = REG_BITS'($urandom);
    if (kind < 3) begin
      ins.alu = addr;
      ins.src = brisc_pkg::FROM_C;
      ins.rw = 1'b1;
    end else if (kind < 6) begin
      ins.alu = addr;
      ins.mw = 1'b1;
    end else begin
      ins.alu = $urandom;
      ins.rw = 1'($urandom);
      case ($urandom % 3)
        0:       ins.src = brisc_pkg::FROM_ALU;
        1:       ins.src = brisc_pkg::FROM_PC4;
        default: ins.src = brisc_pkg::FROM_DELTA;
      endcase
    end
    return ins;
  endfunction

  // One word per line, four lines per set
  function automatic instr_t directed_instr(input int line, input logic store);
    instr_t ins;
    logic [XLEN-1:0] addr;
    ins = bubble();
    addr = XLEN'(line * 16 + (line % 4) * 4);
    ins.alu = addr;
    ins.pc4 = addr + 32'd4;
    ins.rd = REG_BITS'(line);
    ins.size = brisc_pkg::SIZE_W;
    if (store) begin
      ins.mw = 1'b1;
      ins.wdata = {~addr[15:0], addr[15:0]} ^ 32'h5a5a_0000;
    end else begin
      ins.src = brisc_pkg::FROM_C;
      ins.rw = 1'b1;
    end
    return ins;
  endfunction

  task automatic commit_store(input instr_t ins);
    for (int b = 0; b < size_bytes(ins.size); b++) begin
      ref_mem[int'((ins.alu + b) % MEM_BYTES)] = ins.wdata[8*b +: 8];
    end
  endtask

  function automatic logic [XLEN-1:0] predict_load(input instr_t ins);
    logic [XLEN-1:0] value;
    value = '0;
    for (int b = 0; b < size_bytes(ins.size); b++) begin
      value[8*b +: 8] = ref_mem[int'((ins.alu + b) % MEM_BYTES)];
    end
    return value;
  endfunction

  task automatic apply_inputs();
    alu_res_in = drv_instr.alu;
    write_data_in = drv_instr.wdata;
    pc_plus4_in = drv_instr.pc4;
    pc_delta_in = drv_instr.delta;
    rd_in = drv_instr.rd;
    reg_write_in = drv_instr.rw;
    result_src_in = drv_instr.src;
    mem_write_in = drv_instr.mw;
    data_size_in = drv_instr.size;
    stall_in = drv_stall;
    flush_in = drv_flush;
  endtask

  task automatic check_stage();
    check_word("alu_res_out", stage.alu, alu_res_out);
    check_word("pc_plus4_out", stage.pc4, pc_plus4_out);
    check_word("pc_delta_out", stage.delta, pc_delta_out);
    check_reg("rd_out", stage.rd, rd_out);
    check_bit("reg_write_out", stage.rw, reg_write_out);
    check_src("result_src_out", stage.src, result_src_out);
    if (!stall_out && stage.src == brisc_pkg::FROM_C) begin
      check_word($sformatf("load at %h", stage.alu), predict_load(stage), read_data_out);
    end
  endtask

  // Mirror of the stage register at the clock edge
  task automatic update_model();
    if (drv_flush) begin
      stage = bubble();
    end else if (!drv_stall) begin
      if (stage.mw) begin
        commit_store(stage);
      end
      stage = drv_instr;
      pending_valid = 1'b0;
    end
  endtask

  task automatic run_cycle();
    #1;
    drv_instr = pending;
    drv_stall = random_stalls && ($urandom % 8 == 0);
    drv_flush = random_stalls && ($urandom % 32 == 0);
    apply_inputs();
    #1;
    // Stall follows the DUT, a flush waits for a quiet cycle
    if (stall_out) begin
      drv_stall = 1'b1;
      drv_flush = 1'b0;
      apply_inputs();
    end
    @(negedge clk);
    check_stage();
    @(posedge clk);
    update_model();
  endtask

  task automatic issue_instr(input instr_t ins);
    int waited;
    pending = ins;
    pending_valid = 1'b1;
    waited = 0;
    while (pending_valid) begin
      if (waited == WAIT_LIMIT) begin
        stop_on_error("stall never released");
      end
      run_cycle();
      waited++;
    end
  endtask

  initial begin
    void'($urandom(32'h5ca6));
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    rst_n = 1'b0;
    stage = bubble();
    pending = bubble();
    drv_instr = bubble();
    drv_stall = 1'b0;
    drv_flush = 1'b0;
    pending_valid = 1'b0;
    random_stalls = 1'b0;
    apply_inputs();

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("reset reg_write_out", 1'b0, reg_write_out);
    check_src("reset result_src_out", brisc_pkg::FROM_ALU, result_src_out);
    check_bit("reset stall_out", 1'b0, stall_out);
    @(posedge clk);

    // Fill every set four times over, then read it all back
    for (int i = 0; i < TEST_LINES; i++) begin
      issue_instr(directed_instr(i, 1'b1));
    end
    for (int i = 0; i < TEST_LINES; i++) begin
      issue_instr(directed_instr(i, 1'b0));
    end

    random_stalls = 1'b1;
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      issue_instr(random_instr());
    end
    random_stalls = 1'b0;
    issue_instr(bubble());

    $display(">>> PASS");
    $finish;
  end

endmodule

/* vlog.f */
hw/brisc_pkg.sv
hw/store_buffer.sv
hw/dcache.sv
hw/line_memory.sv
hw/cache_stage.sv
hw/mem_stage_top.sv
sim/tb_mem_stage.sv
